// File: Makefile
VERILATOR  = verilator
TOP        = lms_tb
FILELIST   = src.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Done: no errors
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/adapt_sequencer.sv
// round FSM of the predictor
// walks predict, error and update phases, one per clock, after an accepted start

`timescale 1ns/1ps

module adapt_sequencer import lms_ctrl_pkg::*; (
	input logic clk_operation,
	input logic rst,
	input logic start,
	input logic window_full,
	output phase_t phase,
	output logic busy,
	output logic ready
);

	phase_t phase_next;

	always_comb begin
		phase_next = phase;
		case (phase)
			IDLE: begin
				if (start && window_full) begin // only place a start is taken
					phase_next = PRED0;
				end
			end
			PRED0: phase_next = PRED1;
			PRED1: phase_next = ERR;
			ERR: phase_next = UPD0;
			UPD0: phase_next = UPD1;
			UPD1: phase_next = DONE;
			DONE: phase_next = IDLE;
			default: phase_next = IDLE;
		endcase
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			phase <= IDLE;
		end else begin
			phase <= phase_next;
		end
	end

	assign busy = (phase != IDLE);
	assign ready = (phase == DONE); // one cycle per round

endmodule

// File: source/coef_bank.sv
// coefficient registers of the predictor
// each update phase adds step times tap to one lane slice, with saturation

`timescale 1ns/1ps

module coef_bank import lms_fmt_pkg::*, lms_ctrl_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int FRAC = 12,
	parameter int TAPS = 16,
	parameter int LANES = 8
) (
	input logic clk_operation,
	input logic rst,
	input phase_t phase,
	input tap_vec_t window,
	input sample_t step,
	output tap_vec_t coefs
);

	localparam int BASE_W = $clog2(TAPS);

	logic [BASE_W-1:0] base; // first coefficient of the slice
	logic upd_en;
	logic signed [2*DATA_W-1:0] prod [LANES];
	acc_t delta [LANES];
	sample_t new_coef [LANES];

	assign upd_en = (phase == UPD0) || (phase == UPD1);
	assign base = (phase == UPD1) ? BASE_W'(LANES) : '0;

	// one saturating update per lane
	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			prod[l] = step * window[base + l];
			delta[l] = acc_t'(prod[l]) >>> FRAC; // floors toward minus infinity
			new_coef[l] = sat_data(acc_t'(coefs[base + l]) + delta[l]);
		end
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			coefs <= '0;
		end else if (upd_en) begin
			for (int l = 0; l < LANES; l++) begin
				coefs[base + l] <= new_coef[l];
			end
		end
	end

endmodule

// File: source/lms_ctrl_pkg.sv
// control definitions for one adaptation round
// phase encoding shared by the sequencer and the datapath, and the round result

package lms_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		PRED0, // first lane slice of the dot product
		PRED1, // second lane slice
		ERR, // prediction, error and step registered
		UPD0,
		UPD1,
		DONE // ready
	} phase_t;

	typedef struct packed {
		lms_fmt_pkg::sample_t prediction;
		lms_fmt_pkg::sample_t error;
	} round_result_t;

endpackage

// File: source/lms_fmt_pkg.sv
// fixed-point number format for the LMS predictor
// sample, accumulator and window types plus the saturating narrowing helper

package lms_fmt_pkg;

	localparam int PKG_DATA_W = 16;
	localparam int PKG_TAPS = 16;
	localparam int PKG_ACC_W = 2 * PKG_DATA_W + $clog2(PKG_TAPS);

	typedef logic signed [PKG_DATA_W-1:0] sample_t; // sample, coef, error, mu
	typedef logic signed [PKG_ACC_W-1:0] acc_t;
	typedef sample_t [PKG_TAPS-1:0] tap_vec_t; // element 0 is the newest tap

	localparam acc_t SAT_MAX = acc_t'(2 ** (PKG_DATA_W - 1) - 1);
	localparam acc_t SAT_MIN = acc_t'(-(2 ** (PKG_DATA_W - 1)));

	// clamp a wide value into the sample range
	function automatic sample_t sat_data(input acc_t v);
		sample_t r;
		if (v > SAT_MAX) begin
			r = sample_t'(SAT_MAX);
		end else if (v < SAT_MIN) begin
			r = sample_t'(SAT_MIN);
		end else begin
			r = sample_t'(v); // in range, drop the sign copies
		end
		return r;
	endfunction

endpackage

// File: source/lms_top.sv
// fixed-point LMS adaptive predictor, top level
// joins the tap window, round sequencer, predict datapath and coefficient bank

`timescale 1ns/1ps

module lms_top import lms_fmt_pkg::*, lms_ctrl_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int FRAC = 12,
	parameter int TAPS = 16,
	parameter int LANES = 8
) (
	input logic clk_operation,
	input logic rst,
	input logic sample_strobe,
	input sample_t sample,
	input sample_t desired, // value the window is predicting
	input sample_t mu,
	input logic start,
	output logic ready,
	output round_result_t result,
	output tap_vec_t coefs
);

	tap_vec_t window;
	sample_t desired_held;
	sample_t step;
	logic window_full;
	logic busy;
	phase_t phase;

	tap_window #(.TAPS(TAPS)) u_window (
		.clk_operation(clk_operation), .rst(rst),
		.sample_strobe(sample_strobe), .sample(sample), .desired(desired),
		.busy(busy), .window(window), .desired_held(desired_held),
		.window_full(window_full)
	);

	adapt_sequencer u_seq (
		.clk_operation(clk_operation), .rst(rst), .start(start),
		.window_full(window_full), .phase(phase), .busy(busy), .ready(ready)
	);

	predict_unit #(.DATA_W(DATA_W), .FRAC(FRAC), .TAPS(TAPS), .LANES(LANES)) u_predict (
		.clk_operation(clk_operation), .rst(rst), .phase(phase),
		.window(window), .coefs(coefs), .desired_held(desired_held),
		.mu(mu), .result(result), .step(step)
	);

	coef_bank #(.DATA_W(DATA_W), .FRAC(FRAC), .TAPS(TAPS), .LANES(LANES)) u_coef (
		.clk_operation(clk_operation), .rst(rst), .phase(phase),
		.window(window), .step(step), .coefs(coefs)
	);

endmodule

// File: source/predict_unit.sv
// dot product of window and coefficients over two lane passes
// then prediction, error and the mu-scaled step, all saturated

`timescale 1ns/1ps

module predict_unit import lms_fmt_pkg::*, lms_ctrl_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int FRAC = 12,
	parameter int TAPS = 16,
	parameter int LANES = 8
) (
	input logic clk_operation,
	input logic rst,
	input phase_t phase,
	input tap_vec_t window,
	input tap_vec_t coefs,
	input sample_t desired_held,
	input sample_t mu,
	output round_result_t result,
	output sample_t step
);

	localparam int BASE_W = $clog2(TAPS);

	logic [BASE_W-1:0] base; // first tap of the active slice
	logic signed [2*DATA_W-1:0] prod [LANES];
	logic signed [2*DATA_W-1:0] mu_err;
	acc_t lane_sum;
	acc_t acc;
	sample_t pred_c;
	sample_t err_c;
	sample_t step_c;

	assign base = (phase == PRED1) ? BASE_W'(LANES) : '0;

	always_comb begin
		lane_sum = '0;
		for (int l = 0; l < LANES; l++) begin
			prod[l] = window[base + l] * coefs[base + l];
			lane_sum = lane_sum + acc_t'(prod[l]);
		end
	end

	always_ff @(posedge clk_operation) begin
		if (!rst || phase == IDLE) begin
			acc <= '0; // each round starts from zero
		end else if (phase == PRED0 || phase == PRED1) begin
			acc <= acc + lane_sum;
		end
	end

	always_comb begin
		pred_c = sat_data(acc >>> FRAC);
		err_c = sat_data(acc_t'(desired_held) - acc_t'(pred_c));
		mu_err = mu * err_c;
		step_c = sat_data(acc_t'(mu_err) >>> FRAC);
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			result <= '0;
		end else if (phase == ERR) begin
			result <= '{prediction: pred_c, error: err_c}; // held until next round
		end
	end

	always_ff @(posedge clk_operation) begin
		if (phase == ERR) begin
			step <= step_c;
		end
	end

endmodule

// File: source/tap_window.sv
// sample delay line for the predictor
// shifts new samples into tap 0 and keeps the desired value aligned with them

`timescale 1ns/1ps

module tap_window import lms_fmt_pkg::*; #(
	parameter int TAPS = 16
) (
	input logic clk_operation,
	input logic rst,
	input logic sample_strobe,
	input sample_t sample,
	input sample_t desired,
	input logic busy,
	output tap_vec_t window,
	output sample_t desired_held,
	output logic window_full
);

	logic [$clog2(TAPS+1)-1:0] fill_cnt; // samples seen, stops at TAPS
	logic take;

	assign take = sample_strobe && !busy; // strobes during a round are dropped
	assign window_full = (fill_cnt == TAPS);

	always_ff @(posedge clk_operation) begin
		if (take) begin
			window <= {window[TAPS-2:0], sample}; // oldest tap falls off
			desired_held <= desired;
		end
	end

	always_ff @(posedge clk_operation) begin
		if (!rst) begin
			fill_cnt <= '0;
		end else if (take && !window_full) begin
			fill_cnt <= fill_cnt + 1'b1;
		end
	end

endmodule

// File: src.f
source/lms_fmt_pkg.sv
source/lms_ctrl_pkg.sv
source/tap_window.sv
source/adapt_sequencer.sv
source/predict_unit.sv
source/coef_bank.sv
source/lms_top.sv
verif/lms_assert.sv
verif/lms_checker.sv
verif/lms_tb.sv

// File: verif/lms_assert.sv
// protocol assertions for the round sequencer
// bound into adapt_sequencer from the testbench

`timescale 1ns/1ps

module lms_assert import lms_ctrl_pkg::*; (
	input logic clk_operation,
	input logic rst,
	input logic start,
	input logic window_full,
	input logic ready,
	input phase_t phase
);

	logic take;

	assign take = (phase == IDLE) && start && window_full; // accepted start

	a_stay_idle: assert property (@(posedge clk_operation) disable iff (!rst)
		(phase == IDLE && !(start && window_full)) |=> (phase == IDLE))
		else $error("phase left IDLE without an accepted start");

	a_ready_time: assert property (@(posedge clk_operation) disable iff (!rst)
		take |-> ##6 ready)
		else $error("ready did not follow an accepted start after six edges");

	a_ready_single: assert property (@(posedge clk_operation) disable iff (!rst)
		ready |=> !ready)
		else $error("ready held high for more than one cycle");

endmodule

// File: verif/lms_checker.sv
// reference model and result checker for the LMS predictor
// mirrors window and coefficients in integers, compares on every ready

`timescale 1ns/1ps

module lms_checker import lms_fmt_pkg::*, lms_ctrl_pkg::*; #(
	parameter int DATA_W = 16,
	parameter int FRAC = 12,
	parameter int TAPS = 16
) (
	input logic clk_operation,
	input logic rst,
	input logic sample_strobe,
	input sample_t sample,
	input sample_t desired,
	input sample_t mu,
	input logic start,
	input logic ready,
	input round_result_t result,
	input tap_vec_t coefs,
	input logic report,
	output int err_total
);

	localparam longint MAX_V = (longint'(1) <<< (DATA_W - 1)) - 1;
	localparam longint MIN_V = -(longint'(1) <<< (DATA_W - 1));

	longint win_m [TAPS]; // index 0 is the newest sample
	longint coef_m [TAPS];
	longint desired_m;
	longint pred_m;
	longint err_m;
	int fill;
	int busy_cnt = 0; // edges left in a round, DONE at 1
	int rounds = 0;
	int value_errs = 0;
	int pulse_errs = 0;
	logic after_reset = 1'b0;
	logic accept;

	assign err_total = value_errs + pulse_errs;

	function automatic longint clamp(input longint v);
		longint r;
		if (v > MAX_V) begin
			r = MAX_V;
		end else if (v < MIN_V) begin
			r = MIN_V;
		end else begin
			r = v;
		end
		return r;
	endfunction

	task automatic compare(input string what, input sample_t got, input longint exp);
		if ($isunknown(got) || longint'(got) != exp) begin
			value_errs++;
			$display("CHECK FAILED t=%0d ns: %s is %0d, model gives %0d", $time, what, got, exp);
		end
	endtask

	// prediction, error and step are taken in the error phase, with mu as it is then
	task automatic model_round();
		longint acc;
		longint step;
		acc = 0;
		for (int i = 0; i < TAPS; i++) begin
			acc += win_m[i] * coef_m[i];
		end
		pred_m = clamp(acc >>> FRAC);
		err_m = clamp(desired_m - pred_m);
		step = clamp((longint'(mu) * err_m) >>> FRAC);
		for (int i = 0; i < TAPS; i++) begin
			coef_m[i] = clamp(coef_m[i] + ((step * win_m[i]) >>> FRAC));
		end
	endtask

	task automatic check_round();
		rounds++;
		compare("prediction", result.prediction, pred_m);
		compare("error", result.error, err_m);
		for (int i = 0; i < TAPS; i++) begin
			compare($sformatf("coef %0d", i), coefs[i], coef_m[i]);
		end
	endtask

	task automatic check_reset();
		if (ready !== 1'b0) begin
			value_errs++;
			$display("CHECK FAILED t=%0d ns: ready is not low after reset", $time);
		end
		compare("prediction after reset", result.prediction, 0);
		compare("error after reset", result.error, 0);
		for (int i = 0; i < TAPS; i++) begin
			compare($sformatf("coef %0d after reset", i), coefs[i], 0);
		end
	endtask

	always @(posedge clk_operation) begin
		if (!rst) begin
			fill = 0;
			busy_cnt = 0;
			desired_m = 0;
			after_reset = 1'b1;
			for (int i = 0; i < TAPS; i++) begin
				win_m[i] = 0;
				coef_m[i] = 0;
			end
		end else begin
			if (after_reset) begin
				check_reset();
				after_reset = 1'b0;
			end
			if (ready !== (busy_cnt == 1)) begin
				pulse_errs++;
				if (busy_cnt == 1) begin
					$display("ready pulse missing at the end of round %0d, time %0d ns",
						rounds + 1, $time);
				end else begin
					$display("ready pulse at time %0d ns with no accepted start", $time);
				end
			end
			if (busy_cnt == 4) begin
				model_round(); // error phase
			end
			if (busy_cnt == 1) begin
				check_round();
			end
			if (busy_cnt > 0) begin
				busy_cnt--; // strobes and starts are dropped here
			end else begin
				accept = start && (fill == TAPS); // fill before this strobe counts
				if (sample_strobe) begin
					for (int i = TAPS - 1; i > 0; i--) begin
						win_m[i] = win_m[i-1];
					end
					win_m[0] = longint'(sample);
					desired_m = longint'(desired);
					if (fill < TAPS) begin
						fill++;
					end
				end
				if (accept) begin
					busy_cnt = 6;
				end
			end
			if (report) begin
				$display("checker: %0d rounds, %0d value errors, %0d ready errors",
					rounds, value_errs, pulse_errs);
			end
		end
	end

endmodule

// File: verif/lms_tb.sv
// testbench for the LMS predictor
// LFSR driven samples and rounds, checker and sequencer assertions attached

`timescale 1ns/1ps

module lms_tb import lms_fmt_pkg::*, lms_ctrl_pkg::*; ();

	localparam int DATA_W = 16;
	localparam int FRAC = 12;
	localparam int TAPS = 16;
	localparam int LANES = 8;
	localparam int ROUNDS = 40;
	localparam int SAT_ROUNDS = 5;
	localparam int TIMEOUT_CYCLES = 16 + 45 * 12 + 100;

	logic clk_operation;
	logic rst;
	logic sample_strobe;
	sample_t sample;
	sample_t desired;
	sample_t mu;
	logic start;
	logic ready;
	round_result_t result;
	tap_vec_t coefs;
	logic report;
	int err_total;
	int cycles;
	logic [15:0] lfsr_state;
	sample_t hist [6]; // recent samples, 0 newest

	lms_top #(.DATA_W(DATA_W), .FRAC(FRAC), .TAPS(TAPS), .LANES(LANES)) u_dut (
		.clk_operation(clk_operation), .rst(rst), .sample_strobe(sample_strobe),
		.sample(sample), .desired(desired), .mu(mu), .start(start),
		.ready(ready), .result(result), .coefs(coefs)
	);

	lms_checker #(.DATA_W(DATA_W), .FRAC(FRAC), .TAPS(TAPS)) u_check (
		.clk_operation(clk_operation), .rst(rst), .sample_strobe(sample_strobe),
		.sample(sample), .desired(desired), .mu(mu), .start(start), .ready(ready),
		.result(result), .coefs(coefs), .report(report), .err_total(err_total)
	);

	bind adapt_sequencer lms_assert u_seq_assert (
		.clk_operation(clk_operation), .rst(rst), .start(start),
		.window_full(window_full), .ready(ready), .phase(phase)
	);

	always #50 clk_operation = ~clk_operation;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int draw_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[15]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// desired is a fixed mix of recent samples, a target the taps can learn
	task automatic new_sample(output sample_t x, output sample_t d);
		int v;
		v = draw_bits(11) - 1024;
		for (int i = 5; i > 0; i--) begin
			hist[i] = hist[i-1];
		end
		hist[0] = sample_t'(v);
		d = sample_t'((2 * int'(hist[0]) + int'(hist[2]) - int'(hist[5])) >>> 2);
		x = hist[0];
	endtask

	task automatic full_scale(output sample_t x, output sample_t d);
		if (draw_bits(1) == 1) begin
			x = sample_t'(32767 - draw_bits(6));
			d = sample_t'(-32768);
		end else begin
			x = sample_t'(-32768 + draw_bits(6));
			d = sample_t'(32767);
		end
	endtask

	// one strobe, one start, then a stray start and strobe while busy
	task automatic apply_round(input sample_t x, input sample_t d, input sample_t mu_v);
		sample_strobe <= 1'b1;
		sample <= x;
		desired <= d;
		mu <= mu_v;
		@(posedge clk_operation);
		sample_strobe <= 1'b0;
		start <= 1'b1;
		@(posedge clk_operation);
		start <= 1'b0;
		@(posedge clk_operation);
		start <= 1'b1;
		sample_strobe <= 1'b1;
		sample <= sample_t'(draw_bits(16));
		@(posedge clk_operation);
		start <= 1'b0;
		sample_strobe <= 1'b0;
		@(posedge clk_operation);
		while (!ready) begin
			@(posedge clk_operation);
		end
	endtask

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_operation);
			cycles++;
		end
		$display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		sample_t x;
		sample_t d;
		clk_operation = 1'b0;
		rst = 1'b0;
		sample_strobe = 1'b0;
		sample = '0;
		desired = '0;
		mu = '0;
		start = 1'b0;
		report = 1'b0;
		lfsr_state = 16'd23;
		for (int i = 0; i < 6; i++) begin
			hist[i] = '0;
		end
		repeat (4) @(posedge clk_operation);
		rst <= 1'b1;
		for (int i = 0; i < TAPS; i++) begin
			new_sample(x, d);
			sample_strobe <= 1'b1;
			sample <= x;
			desired <= d;
			start <= (i == TAPS / 2); // window not full yet
			@(posedge clk_operation);
		end
		sample_strobe <= 1'b0;
		start <= 1'b0;
		@(posedge clk_operation);
		for (int r = 0; r < ROUNDS; r++) begin
			new_sample(x, d);
			apply_round(x, d, sample_t'(256 + draw_bits(10)));
		end
		for (int r = 0; r < SAT_ROUNDS; r++) begin
			full_scale(x, d);
			apply_round(x, d, sample_t'(32767 - draw_bits(4)));
		end
		repeat (3) @(posedge clk_operation);
		report <= 1'b1;
		@(posedge clk_operation);
		report <= 1'b0;
		@(posedge clk_operation);
		if (err_total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
